/* rtl/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// physical register file size
`define RENAME_NUM_PHYS_REGS 64

// architectural registers visible to software
`define RENAME_NUM_ARCH_REGS 32

// micro-ops renamed per cycle
`define RENAME_WIDTH 2

// register data word
`define RENAME_DATA_WIDTH 64

// immediate field as it comes from decode
`define RENAME_IMM_WIDTH 16

`endif

/* rtl/uop_pkg.sv */
`include "rename_config.svh"

// types describing a decoded micro-op
package uop_pkg;

  // architectural register index, 5 bits for 32 regs
  typedef logic [$clog2(`RENAME_NUM_ARCH_REGS)-1:0] arch_reg_t;

  // raw immediate operand
  // signed, gets extended to the data width in rename
  typedef logic signed [`RENAME_IMM_WIDTH-1:0] imm_t;

endpackage

/* rtl/rename_pkg.sv */
`include "rename_config.svh"

// types on the rename / physical side
package rename_pkg;

  // physical register index, 6 bits for 64 regs
  typedef logic [$clog2(`RENAME_NUM_PHYS_REGS)-1:0] phys_reg_t;

  // read / write pointer into the free list buffer
  // buffer is one slot per physical register
  typedef logic [$clog2(`RENAME_NUM_PHYS_REGS)-1:0] frl_ptr_t;

  // occupancy, one bit wider so a full buffer fits
  typedef logic [$clog2(`RENAME_NUM_PHYS_REGS):0] frl_count_t;

  // register file data word
  typedef logic [`RENAME_DATA_WIDTH-1:0] reg_data_t;

endpackage

/* rtl/rat.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rat (
  input  logic                                        clk,
  input  logic                                        rst_N_in,
  // decoded pair from the instruction queue
  input  logic                                        q_valid,
  input  logic                 [`RENAME_WIDTH-1:0]    instr_valb_sel,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]    instr_dst,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]    instr_src1,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]    instr_src2,
  input  uop_pkg::imm_t        [`RENAME_WIDTH-1:0]    instr_imm,
  output logic                                        q_increment_ready,
  // renamed pair to the reorder buffer
  output logic                                        rob_data_valid,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   rob_dst_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   rob_src1_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   rob_src2_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   rob_old_dst_phys,
  output uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]    rob_dst_arch,
  input  logic                                        rob_ready,
  // free list heads and pop strobes
  output logic                 [2*`RENAME_WIDTH-1:0]  frl_ready,
  input  rename_pkg::phys_reg_t [2*`RENAME_WIDTH-1:0] free_register_data,
  input  logic                                        frl_valid,
  // immediate writes into the register file
  output logic                 [`RENAME_WIDTH-1:0]    regfile_en,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   regfile_index,
  output rename_pkg::reg_data_t [`RENAME_WIDTH-1:0]   regfile_data
);
  import rename_pkg::*;

  localparam int num_slots = `RENAME_WIDTH;
  localparam int imm_pad = `RENAME_DATA_WIDTH - `RENAME_IMM_WIDTH;

  logic making_progress;

  // arch -> phys map
  phys_reg_t map_table [`RENAME_NUM_ARCH_REGS];

  // resolved mappings for the current pair
  phys_reg_t [num_slots-1:0] src1_phys;
  phys_reg_t [num_slots-1:0] src2_phys;
  phys_reg_t [num_slots-1:0] old_dst_phys;
  reg_data_t [num_slots-1:0] imm_ext;

  // whole pair goes or nothing goes
  assign making_progress = q_valid && frl_valid && rob_ready;

  // queue pops on the same edge we consume the pair
  assign q_increment_ready = making_progress;

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      // dst always takes head i
      frl_ready[i] = making_progress;
      // immediate slot also burns head 2+i
      frl_ready[num_slots+i] = making_progress && !instr_valb_sel[i];
    end
  end

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      src1_phys[i] = map_table[instr_src1[i]];
      src2_phys[i] = map_table[instr_src2[i]];
      old_dst_phys[i] = map_table[instr_dst[i]];
      // bypass from older slots in the pair, youngest match wins
      for (int j = 0; j < i; j++) begin
        if (instr_src1[i] == instr_dst[j]) begin
          src1_phys[i] = free_register_data[j];
        end
        if (instr_src2[i] == instr_dst[j]) begin
          src2_phys[i] = free_register_data[j];
        end
        if (instr_dst[i] == instr_dst[j]) begin
          old_dst_phys[i] = free_register_data[j];
        end
      end
      // immediate lives in its own fresh register
      if (!instr_valb_sel[i]) begin
        src2_phys[i] = free_register_data[num_slots+i];
      end
      imm_ext[i] = {{imm_pad{instr_imm[i][`RENAME_IMM_WIDTH-1]}}, instr_imm[i]};
    end
  end

  // control state and the map
  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rob_data_valid <= 1'b0;
      regfile_en <= '0;
      // identity mapping out of reset
      for (int r = 0; r < `RENAME_NUM_ARCH_REGS; r++) begin
        map_table[r] <= phys_reg_t'(r);
      end
    end else begin
      rob_data_valid <= making_progress;
      for (int i = 0; i < num_slots; i++) begin
        regfile_en[i] <= making_progress && !instr_valb_sel[i];
      end
      if (making_progress) begin
        // slot order, so slot 1 overwrites slot 0 on same dst
        for (int i = 0; i < num_slots; i++) begin
          map_table[instr_dst[i]] <= free_register_data[i];
        end
      end
    end
  end

  // payload, only qualified by the valid bits above
  always_ff @(posedge clk) begin
    if (making_progress) begin
      for (int i = 0; i < num_slots; i++) begin
        rob_dst_phys[i] <= free_register_data[i];
        rob_src1_phys[i] <= src1_phys[i];
        rob_src2_phys[i] <= src2_phys[i];
        rob_old_dst_phys[i] <= old_dst_phys[i];
        rob_dst_arch[i] <= instr_dst[i];
        regfile_index[i] <= free_register_data[num_slots+i];
        regfile_data[i] <= imm_ext[i];
      end
    end
  end

endmodule

/* rtl/free_reg_list.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module free_reg_list (
  input  logic                                        clk,
  input  logic                                        rst_N_in,
  // pop strobes from the alias table
  input  logic                 [2*`RENAME_WIDTH-1:0]  frl_ready,
  // registers returned at commit
  input  logic                 [`RENAME_WIDTH-1:0]    commit_valid,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   commit_free_reg,
  // oldest entries, head 0 first
  output rename_pkg::phys_reg_t [2*`RENAME_WIDTH-1:0] free_register_data,
  output logic                                        frl_valid
);
  import rename_pkg::*;

  localparam int num_slots = `RENAME_WIDTH;
  localparam int num_heads = 2 * `RENAME_WIDTH;
  localparam int depth = `RENAME_NUM_PHYS_REGS;
  // everything above the arch regs starts free
  localparam int free_at_reset = `RENAME_NUM_PHYS_REGS - `RENAME_NUM_ARCH_REGS;

  phys_reg_t fifo_mem [depth];
  frl_ptr_t rd_ptr;
  frl_ptr_t wr_ptr;
  frl_count_t count;

  frl_count_t pop_cnt;
  frl_count_t push_cnt;
  frl_ptr_t [num_slots-1:0] push_off;
  logic skip_hole;

  // pointers wrap on their own, depth is a power of two
  always_comb begin
    for (int k = 0; k < num_heads; k++) begin
      free_register_data[k] = fifo_mem[rd_ptr + frl_ptr_t'(k)];
    end
  end

  // need a full set of heads before a pair can go
  assign frl_valid = count >= frl_count_t'(num_heads);

  always_comb begin
    pop_cnt = '0;
    for (int k = 0; k < num_heads; k++) begin
      pop_cnt = pop_cnt + frl_count_t'(frl_ready[k]);
    end
    // last head used while the one before it is not
    // e.g. slot 0 register-register, slot 1 immediate
    skip_hole = frl_ready[num_heads-1] && !frl_ready[num_heads-2];
  end

  // compact the commit slots onto the tail
  always_comb begin
    push_cnt = '0;
    for (int s = 0; s < num_slots; s++) begin
      push_off[s] = frl_ptr_t'(push_cnt);
      push_cnt = push_cnt + frl_count_t'(commit_valid[s]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rd_ptr <= '0;
      wr_ptr <= frl_ptr_t'(free_at_reset);
      count <= frl_count_t'(free_at_reset);
      // registers 32..63 in ascending order
      for (int k = 0; k < free_at_reset; k++) begin
        fifo_mem[k] <= phys_reg_t'(`RENAME_NUM_ARCH_REGS + k);
      end
    end else begin
      // move the unused head into the slot being consumed
      // so it stays at the front after the pointer moves
      if (skip_hole) begin
        fifo_mem[rd_ptr + frl_ptr_t'(num_heads-1)] <= free_register_data[num_heads-2];
      end
      for (int s = 0; s < num_slots; s++) begin
        if (commit_valid[s]) begin
          fifo_mem[wr_ptr + push_off[s]] <= commit_free_reg[s];
        end
      end
      rd_ptr <= rd_ptr + frl_ptr_t'(pop_cnt);
      wr_ptr <= wr_ptr + frl_ptr_t'(push_cnt);
      count <= count + push_cnt - pop_cnt;
    end
  end

endmodule

/* rtl/rename_top.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_top (
  input  logic                                      clk,
  input  logic                                      rst_N_in,
  // instruction queue
  input  logic                                      q_valid,
  input  logic                 [`RENAME_WIDTH-1:0]  instr_valb_sel,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_dst,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_src1,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_src2,
  input  uop_pkg::imm_t        [`RENAME_WIDTH-1:0]  instr_imm,
  output logic                                      q_increment_ready,
  // reorder buffer
  input  logic                                      rob_ready,
  output logic                                      rob_data_valid,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_dst_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_src1_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_src2_phys,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_old_dst_phys,
  output uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  rob_dst_arch,
  // commit frees
  input  logic                 [`RENAME_WIDTH-1:0]  commit_valid,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] commit_free_reg,
  // register file write ports for immediates
  output logic                 [`RENAME_WIDTH-1:0]  regfile_en,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] regfile_index,
  output rename_pkg::reg_data_t [`RENAME_WIDTH-1:0] regfile_data
);
  import rename_pkg::*;

  // free list link
  logic [2*`RENAME_WIDTH-1:0] frl_ready;
  phys_reg_t [2*`RENAME_WIDTH-1:0] free_register_data;
  logic frl_valid;

  rat u_rat (
    .clk                (clk),
    .rst_N_in           (rst_N_in),
    .q_valid            (q_valid),
    .instr_valb_sel     (instr_valb_sel),
    .instr_dst          (instr_dst),
    .instr_src1         (instr_src1),
    .instr_src2         (instr_src2),
    .instr_imm          (instr_imm),
    .q_increment_ready  (q_increment_ready),
    .rob_data_valid     (rob_data_valid),
    .rob_dst_phys       (rob_dst_phys),
    .rob_src1_phys      (rob_src1_phys),
    .rob_src2_phys      (rob_src2_phys),
    .rob_old_dst_phys   (rob_old_dst_phys),
    .rob_dst_arch       (rob_dst_arch),
    .rob_ready          (rob_ready),
    .frl_ready          (frl_ready),
    .free_register_data (free_register_data),
    .frl_valid          (frl_valid),
    .regfile_en         (regfile_en),
    .regfile_index      (regfile_index),
    .regfile_data       (regfile_data)
  );

  // commit pushes are independent of rename stalls
  free_reg_list u_free_reg_list (
    .clk                (clk),
    .rst_N_in           (rst_N_in),
    .frl_ready          (frl_ready),
    .commit_valid       (commit_valid),
    .commit_free_reg    (commit_free_reg),
    .free_register_data (free_register_data),
    .frl_valid          (frl_valid)
  );

endmodule

/* test/rename_checker.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_checker (
  input  logic                                      clk,
  input  logic                                      rst_N_in,
  input  logic                                      q_valid,
  input  logic                 [`RENAME_WIDTH-1:0]  instr_valb_sel,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_dst,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_src1,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  instr_src2,
  input  uop_pkg::imm_t        [`RENAME_WIDTH-1:0]  instr_imm,
  input  logic                                      q_increment_ready,
  input  logic                                      rob_ready,
  input  logic                                      rob_data_valid,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_dst_phys,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_src1_phys,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_src2_phys,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] rob_old_dst_phys,
  input  uop_pkg::arch_reg_t   [`RENAME_WIDTH-1:0]  rob_dst_arch,
  input  logic                 [`RENAME_WIDTH-1:0]  commit_valid,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] commit_free_reg,
  input  logic                 [`RENAME_WIDTH-1:0]  regfile_en,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] regfile_index,
  input  rename_pkg::reg_data_t [`RENAME_WIDTH-1:0] regfile_data
);
  import rename_pkg::*;

  int err_count = 0;
  int pair_count = 0;

  // model state: arch map and fifo of free regs
  phys_reg_t model_map [`RENAME_NUM_ARCH_REGS];
  phys_reg_t free_q [$];

  // expectation for the edge after acceptance
  logic pend_valid = 1'b0;
  logic [1:0] exp_en;
  phys_reg_t exp_dst [2];
  phys_reg_t exp_src1 [2];
  phys_reg_t exp_src2 [2];
  phys_reg_t exp_old [2];
  logic [4:0] exp_arch [2];
  phys_reg_t exp_idx [2];
  reg_data_t exp_data [2];

  task automatic compare(input string what, input int slot, input logic [63:0] got,
                         input logic [63:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: slot %0d %s got %0h expected %0h", $time, slot, what, got, exp);
    end
  endtask

  always @(posedge clk) begin
    logic progress;
    phys_reg_t keep [$];
    if (!rst_N_in) begin
      for (int r = 0; r < `RENAME_NUM_ARCH_REGS; r++) begin
        model_map[r] = phys_reg_t'(r);
      end
      free_q.delete();
      for (int k = `RENAME_NUM_ARCH_REGS; k < `RENAME_NUM_PHYS_REGS; k++) begin
        free_q.push_back(phys_reg_t'(k));
      end
      pend_valid = 1'b0;
    end else begin
      // outputs from the previous accepting edge
      compare("rob_data_valid", 0, 64'(rob_data_valid), 64'(pend_valid));
      for (int i = 0; i < 2; i++) begin
        compare("regfile_en", i, 64'(regfile_en[i]), pend_valid ? 64'(exp_en[i]) : 64'd0);
        if (pend_valid) begin
          compare("rob_dst_phys", i, 64'(rob_dst_phys[i]), 64'(exp_dst[i]));
          compare("rob_src1_phys", i, 64'(rob_src1_phys[i]), 64'(exp_src1[i]));
          compare("rob_src2_phys", i, 64'(rob_src2_phys[i]), 64'(exp_src2[i]));
          compare("rob_old_dst_phys", i, 64'(rob_old_dst_phys[i]), 64'(exp_old[i]));
          compare("rob_dst_arch", i, 64'(rob_dst_arch[i]), 64'(exp_arch[i]));
          if (exp_en[i]) begin
            compare("regfile_index", i, 64'(regfile_index[i]), 64'(exp_idx[i]));
            compare("regfile_data", i, regfile_data[i], exp_data[i]);
          end
        end
      end
      if (pend_valid) pair_count++;
      // need four free regs, a valid pair and rob room
      progress = q_valid && rob_ready && (free_q.size() >= 4);
      compare("q_increment_ready", 0, 64'(q_increment_ready), 64'(progress));
      pend_valid = progress;
      if (progress) begin
        for (int i = 0; i < 2; i++) begin
          exp_dst[i] = free_q[i];
          exp_arch[i] = instr_dst[i];
          exp_src1[i] = model_map[instr_src1[i]];
          exp_src2[i] = model_map[instr_src2[i]];
          exp_old[i] = model_map[instr_dst[i]];
          // slot 1 sees slot 0's fresh dst
          if (i == 1) begin
            if (instr_src1[1] == instr_dst[0]) exp_src1[1] = exp_dst[0];
            if (instr_src2[1] == instr_dst[0]) exp_src2[1] = exp_dst[0];
            if (instr_dst[1] == instr_dst[0]) exp_old[1] = exp_dst[0];
          end
          exp_en[i] = !instr_valb_sel[i];
          exp_idx[i] = free_q[2+i];
          exp_data[i] = reg_data_t'(64'($signed(instr_imm[i])));
          if (exp_en[i]) exp_src2[i] = free_q[2+i];
        end
        model_map[instr_dst[0]] = exp_dst[0];
        model_map[instr_dst[1]] = exp_dst[1];
        // unused immediate heads stay at the front
        keep.delete();
        for (int i = 0; i < 2; i++) begin
          if (!exp_en[i]) keep.push_back(free_q[2+i]);
        end
        repeat (4) void'(free_q.pop_front());
        while (keep.size() > 0) free_q.push_front(keep.pop_back());
      end
      for (int i = 0; i < 2; i++) begin
        if (commit_valid[i]) free_q.push_back(commit_free_reg[i]);
      end
    end
  end

endmodule

/* test/rename_tb.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_tb;
  import uop_pkg::*;
  import rename_pkg::*;

  localparam int total_cycles = 1100;

  logic clk = 1'b0;
  logic rst_N_in;
  logic q_valid;
  logic [1:0] instr_valb_sel;
  arch_reg_t [1:0] instr_dst;
  arch_reg_t [1:0] instr_src1;
  arch_reg_t [1:0] instr_src2;
  imm_t [1:0] instr_imm;
  logic q_increment_ready;
  logic rob_ready;
  logic rob_data_valid;
  phys_reg_t [1:0] rob_dst_phys;
  phys_reg_t [1:0] rob_src1_phys;
  phys_reg_t [1:0] rob_src2_phys;
  phys_reg_t [1:0] rob_old_dst_phys;
  arch_reg_t [1:0] rob_dst_arch;
  logic [1:0] commit_valid;
  phys_reg_t [1:0] commit_free_reg;
  logic [1:0] regfile_en;
  phys_reg_t [1:0] regfile_index;
  reg_data_t [1:0] regfile_data;

  logic [31:0] lcg_state = 32'hf15058cd;
  int cyc = 0;
  int tb_errors = 0;
  int last_errors = 0;
  logic replay_en = 1'b1;
  // freed regs waiting to be committed
  phys_reg_t replay_reg [$];
  int replay_at [$];

  always #5 clk = ~clk;

  rename_top dut (.*);

  rename_checker u_checker (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // collect retired mappings, release after a random delay
  always @(posedge clk) begin
    int at;
    cyc++;
    if (rst_N_in && rob_data_valid) begin
      for (int i = 0; i < 2; i++) begin
        at = cyc + 1 + int'(next_rand() % 8);
        if (replay_at.size() > 0 && replay_at[$] > at) at = replay_at[$];
        replay_reg.push_back(rob_old_dst_phys[i]);
        replay_at.push_back(at);
        // immediate temp reg retires with its micro-op
        if (regfile_en[i]) begin
          replay_reg.push_back(regfile_index[i]);
          replay_at.push_back(at);
        end
      end
    end
  end

  always @(negedge clk) begin
    commit_valid = 2'b00;
    for (int i = 0; i < 2; i++) begin
      if (replay_en && replay_at.size() > 0 && replay_at[0] <= cyc) begin
        commit_valid[i] = 1'b1;
        commit_free_reg[i] = replay_reg.pop_front();
        void'(replay_at.pop_front());
      end
    end
  end

  // one pair per falling edge, fields filled by the lcg
  task automatic drive_pair(input logic [1:0] valb, input int bypass_pct, input int ready_pct);
    @(negedge clk);
    q_valid = 1'b1;
    instr_valb_sel = valb;
    for (int i = 0; i < 2; i++) begin
      instr_dst[i] = arch_reg_t'(next_rand() >> 8);
      instr_src1[i] = arch_reg_t'(next_rand() >> 8);
      instr_src2[i] = arch_reg_t'(next_rand() >> 8);
      instr_imm[i] = imm_t'(next_rand() >> 4);
    end
    if ((next_rand() >> 8) % 100 < bypass_pct) instr_src1[1] = instr_dst[0];
    if ((next_rand() >> 8) % 100 < bypass_pct) instr_src2[1] = instr_dst[0];
    if ((next_rand() >> 8) % 100 < bypass_pct) instr_dst[1] = instr_dst[0];
    rob_ready = ((next_rand() >> 8) % 100) < ready_pct;
  endtask

  task automatic finish_test(input int num, input string name);
    @(negedge clk);
    q_valid = 1'b0;
    repeat (2) @(negedge clk);
    $display("test %0d %s done, %0d new errors", num, name,
             u_checker.err_count + tb_errors - last_errors);
    last_errors = u_checker.err_count + tb_errors;
  endtask

  initial begin
    #(total_cycles * 2 * 10);
    $display("watchdog timeout, the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst_N_in = 1'b0;
    q_valid = 1'b0;
    instr_valb_sel = 2'b11;
    instr_dst = '0;
    instr_src1 = '0;
    instr_src2 = '0;
    instr_imm = '0;
    rob_ready = 1'b1;
    commit_valid = '0;
    commit_free_reg = '0;
    repeat (5) @(negedge clk);
    rst_N_in = 1'b1;

    // identity sources, untouched dsts
    for (int c = 0; c < 16; c++) begin
      drive_pair(2'b11, 0, 100);
      instr_dst[0] = arch_reg_t'(2 * (c % 16));
      instr_dst[1] = arch_reg_t'(2 * (c % 16) + 1);
      instr_src1 = instr_dst;
      instr_src2 = instr_dst;
    end
    finish_test(1, "register pairs after reset");

    for (int c = 0; c < 40; c++) drive_pair(2'(next_rand() >> 12), 0, 100);
    finish_test(2, "immediate operands");

    for (int c = 0; c < 40; c++) drive_pair(2'(next_rand() >> 12), 60, 100);
    finish_test(3, "intra-pair bypass");

    for (int c = 0; c < 40; c++) drive_pair(2'(next_rand() >> 12), 20, 40);
    finish_test(4, "rob back-pressure");

    // no commits, list must run dry
    replay_en = 1'b0;
    for (int c = 0; c < 40; c++) drive_pair(2'(next_rand() >> 12), 20, 100);
    @(negedge clk);
    if (q_increment_ready !== 1'b0) begin
      tb_errors++;
      $display("** Error at %0t: q_increment_ready high with the free list drained", $time);
    end
    finish_test(5, "free list drain");

    replay_en = 1'b1;
    for (int c = 0; c < 800; c++) drive_pair(2'(next_rand() >> 12), 25, 80);
    finish_test(6, "commit recycle and random run");

    $display("pairs checked %0d, checker errors %0d, other errors %0d",
             u_checker.pair_count, u_checker.err_count, tb_errors);
    if (u_checker.err_count == 0 && tb_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+rtl
rtl/uop_pkg.sv
rtl/rename_pkg.sv
rtl/rat.sv
rtl/free_reg_list.sv
rtl/rename_top.sv
test/rename_checker.sv
test/rename_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rename testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f project.f --top-module rename_tb -o rename_sim

./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 1
fi
exit 0
